// File: rtl/dm_pkg.sv
package dm_pkg;

	// access mode carried with every request
	// loads use all five sizes, stores only DM_W, DM_H and DM_B
	typedef enum logic [2:0] {
		DM_NONE = 3'd0,
		DM_W    = 3'd1,
		DM_H    = 3'd2,
		DM_HU   = 3'd3,
		DM_B    = 3'd4,
		DM_BU   = 3'd5
	} dm_mode_e;

	// memory geometry
	// 256 words of 32 bits, so 1 KiB of byte space
	localparam int DM_WORDS = 256;

	// width of a word index
	localparam int DM_INDEX_W = 8;

	// byte lanes in one word
	localparam int DM_LANES = 4;

	// inclusive byte-address window of legal accesses
	localparam logic [31:0] DM_ADDR_LB = 32'h0000_0000;
	localparam logic [31:0] DM_ADDR_UB = 32'h0000_03ff;

endpackage

// File: rtl/dm_ram_if.sv
interface dm_ram_if;

	// byte lane mask, one bit per lane, zero means no write
	logic [dm_pkg::DM_LANES-1:0] be;

	// word index into the array
	logic [dm_pkg::DM_INDEX_W-1:0] index;

	// lane data, already placed on the right lanes
	logic [31:0] wdata;

	// registered read word, one cycle after the index
	logic [31:0] rdata;

	// requester side
	modport src (
		output be,
		output index,
		output wdata,
		input  rdata
	);

	// memory side
	modport ram (
		input  be,
		input  index,
		input  wdata,
		output rdata
	);

endinterface

// File: rtl/dm_access_check.sv
module dm_access_check (
	input  logic [31:0]     read_addr,
	input  logic [31:0]     write_addr,
	input  logic [31:0]     write_data,
	input  logic            write_enable,
	input  logic            stop,
	input  dm_pkg::dm_mode_e mode,
	output logic            valid,
	output logic [31:0]     test_m_addr,
	dm_ram_if.src           req
);

	logic [31:0] op_addr;
	logic        in_window;
	logic        aligned;
	logic        store_ok;
	logic [dm_pkg::DM_LANES-1:0] lane_mask;
	logic [31:0] lane_data;

	// a store uses the write address, anything else the read address
	assign op_addr = write_enable ? write_addr : read_addr;

	// window test by offset from the lower bound
	// an address below the bound wraps to a large offset and fails
	assign in_window = (op_addr - dm_pkg::DM_ADDR_LB) <=
		(dm_pkg::DM_ADDR_UB - dm_pkg::DM_ADDR_LB);

	always_comb begin
		case (mode)
			dm_pkg::DM_W:                aligned = (op_addr[1:0] == 2'b00);
			dm_pkg::DM_H, dm_pkg::DM_HU: aligned = ~op_addr[0];
			dm_pkg::DM_B, dm_pkg::DM_BU: aligned = 1'b1;
			default:                     aligned = 1'b0;
		endcase
	end

	// no access at all is always accepted
	assign valid = (mode == dm_pkg::DM_NONE) || (in_window && aligned);

	// store gate, stop freezes the stage
	assign store_ok = valid && write_enable && !stop;

	always_comb begin
		lane_mask = '0;
		lane_data = '0;
		if (store_ok) begin
			case (mode)
				dm_pkg::DM_W: begin
					lane_mask = 4'b1111;
					lane_data = write_data;
				end
				dm_pkg::DM_H: begin
					// bit 1 picks upper or lower halfword
					lane_mask = op_addr[1] ? 4'b1100 : 4'b0011;
					lane_data = {2{write_data[15:0]}};
				end
				dm_pkg::DM_B: begin
					// one lane, picked by the low two address bits
					lane_mask[op_addr[1:0]] = 1'b1;
					lane_data = {4{write_data[7:0]}};
				end
				// unsigned modes have no store meaning, nothing is written
				default: begin
					lane_mask = '0;
					lane_data = '0;
				end
			endcase
		end
	end

	assign req.be    = lane_mask;
	assign req.wdata = lane_data;
	assign req.index = op_addr[dm_pkg::DM_INDEX_W+1:2];

	// trace address, word aligned
	assign test_m_addr = {op_addr[31:2], 2'b00};

endmodule

// File: rtl/dm_clear_ctrl.sv
module dm_clear_ctrl (
	input  logic  clk,
	input  logic  rst,
	output logic  busy,
	output logic  test_m_we,
	dm_ram_if.ram req,
	dm_ram_if.src mem
);

	typedef enum logic {
		CLEAR,
		RUN
	} state_e;

	state_e state;
	logic [dm_pkg::DM_INDEX_W-1:0] clr_index;
	logic last_word;

	// clear ends on the highest word index
	assign last_word = (clr_index == dm_pkg::DM_INDEX_W'(dm_pkg::DM_WORDS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= CLEAR;
			clr_index <= '0;
		end else begin
			case (state)
				CLEAR: begin
					clr_index <= clr_index + 1'b1;
					if (last_word) begin
						state <= RUN;
					end
				end
				default: begin
					// stay in RUN until the next reset
					state <= RUN;
				end
			endcase
		end
	end

	// one word is zeroed per cycle while busy
	assign busy = (state == CLEAR);

	// during clear the sequencer owns the port
	// user requests in that window are dropped
	assign mem.be    = busy ? '1 : req.be;
	assign mem.index = busy ? clr_index : req.index;
	assign mem.wdata = busy ? 32'h0 : req.wdata;

	// read word goes back unchanged
	assign req.rdata = mem.rdata;

	// trace strobe for user stores only
	assign test_m_we = !busy && (|req.be);

endmodule

// File: rtl/dm_ram.sv
module dm_ram (
	input  logic  clk,
	dm_ram_if.ram mem
);

	// word array, no reset, cleared by the sequencer instead
	logic [31:0] mem_array [dm_pkg::DM_WORDS];

	always_ff @(posedge clk) begin
		// each enabled lane takes its byte
		for (int lane = 0; lane < dm_pkg::DM_LANES; lane++) begin
			if (mem.be[lane]) begin
				mem_array[mem.index][8*lane +: 8] <= mem.wdata[8*lane +: 8];
			end
		end
		// synchronous read, old word when read and write collide
		mem.rdata <= mem_array[mem.index];
	end

endmodule

// File: rtl/dm_load_extend.sv
module dm_load_extend (
	input  logic             clk,
	input  logic             rst,
	input  dm_pkg::dm_mode_e mode,
	input  logic [31:0]      read_addr,
	input  logic             valid,
	input  logic [31:0]      rdata,
	output logic [31:0]      read_result
);

	dm_pkg::dm_mode_e mode_q;
	logic [1:0]       lo_q;
	logic             valid_q;
	logic [7:0]       byte_sel;
	logic [15:0]      half_sel;

	// request context, lined up with the registered RAM word
	always_ff @(posedge clk) begin
		if (rst) begin
			mode_q  <= dm_pkg::DM_NONE;
			valid_q <= 1'b0;
		end else begin
			mode_q  <= mode;
			valid_q <= valid;
		end
		lo_q <= read_addr[1:0];
	end

	// pick the addressed byte and halfword out of the word
	assign byte_sel = rdata[8*lo_q +: 8];
	assign half_sel = lo_q[1] ? rdata[31:16] : rdata[15:0];

	always_comb begin
		// invalid or empty requests return zero
		read_result = 32'h0;
		if (valid_q) begin
			case (mode_q)
				dm_pkg::DM_W:  read_result = rdata;
				dm_pkg::DM_H:  read_result = {{16{half_sel[15]}}, half_sel};
				dm_pkg::DM_HU: read_result = {16'h0, half_sel};
				dm_pkg::DM_B:  read_result = {{24{byte_sel[7]}}, byte_sel};
				dm_pkg::DM_BU: read_result = {24'h0, byte_sel};
				default:       read_result = 32'h0;
			endcase
		end
	end

endmodule

// File: rtl/dm_top.sv
module dm_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] read_addr,
	input  logic [31:0] write_addr,
	input  logic [31:0] write_data,
	input  logic        write_enable,
	input  logic [2:0]  mode,
	input  logic        stop,
	output logic [31:0] read_result,
	output logic        valid,
	output logic        busy,
	output logic [31:0] test_m_addr,
	output logic        test_m_we,
	output logic [31:0] test_m_wdata
);

	dm_pkg::dm_mode_e mode_e;

	// access side request and memory side request
	dm_ram_if req ();
	dm_ram_if mem ();

	// raw mode bits onto the enum
	assign mode_e = dm_pkg::dm_mode_e'(mode);

	dm_access_check access_check_inst (
		.read_addr    (read_addr),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.write_enable (write_enable),
		.stop         (stop),
		.mode         (mode_e),
		.valid        (valid),
		.test_m_addr  (test_m_addr),
		.req          (req.src)
	);

	dm_clear_ctrl clear_ctrl_inst (
		.clk       (clk),
		.rst       (rst),
		.busy      (busy),
		.test_m_we (test_m_we),
		.req       (req.ram),
		.mem       (mem.src)
	);

	dm_ram ram_inst (
		.clk (clk),
		.mem (mem.ram)
	);

	dm_load_extend load_extend_inst (
		.clk         (clk),
		.rst         (rst),
		.mode        (mode_e),
		.read_addr   (read_addr),
		.valid       (valid),
		.rdata       (req.rdata),
		.read_result (read_result)
	);

	// trace of the raw word, one cycle late
	assign test_m_wdata = req.rdata;

endmodule

// File: verification/dm_checker.sv
module dm_checker (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] read_addr,
	input  logic [31:0] write_addr,
	input  logic [31:0] write_data,
	input  logic        write_enable,
	input  logic [2:0]  mode,
	input  logic        stop,
	input  logic [31:0] read_result,
	input  logic        valid,
	input  logic        busy,
	input  logic [31:0] test_m_addr,
	input  logic        test_m_we,
	input  logic [31:0] test_m_wdata,
	output int          error_count,
	output int          check_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// reference memory, one 32-bit word per index
	logic [31:0] model [dm_pkg::DM_WORDS];
	// a load was issued last cycle and its result is due now
	logic        pend;
	logic [31:0] pend_word;
	logic [31:0] pend_result;
	logic [31:0] op_addr;
	logic        exp_valid;
	logic        exp_we;
	logic [dm_pkg::DM_INDEX_W-1:0] widx;
	// cycles since reset release, the clear takes DM_WORDS of them
	int          clr_cnt;
	logic        exp_busy;

	// inside the window and aligned to the access size
	function automatic logic expect_valid(input logic [2:0] m, input logic [31:0] a);
		logic aligned;
		case (m)
			dm_pkg::DM_NONE: return 1'b1;
			dm_pkg::DM_W: aligned = (a[1:0] == 2'b00);
			dm_pkg::DM_H, dm_pkg::DM_HU: aligned = (a[0] == 1'b0);
			dm_pkg::DM_B, dm_pkg::DM_BU: aligned = 1'b1;
			default: aligned = 1'b0;
		endcase
		return aligned && (a >= dm_pkg::DM_ADDR_LB) && (a <= dm_pkg::DM_ADDR_UB);
	endfunction

	// byte or halfword taken from the word and extended by mode
	function automatic logic [31:0] expect_load(input logic [2:0] m, input logic [31:0] a,
		input logic [31:0] w);
		logic [7:0]  b;
		logic [15:0] h;
		b = 8'(w >> (8 * a[1:0]));
		h = 16'(w >> (16 * a[1]));
		case (m)
			dm_pkg::DM_W:  return w;
			dm_pkg::DM_H:  return {{16{h[15]}}, h};
			dm_pkg::DM_HU: return {16'h0, h};
			dm_pkg::DM_B:  return {{24{b[7]}}, b};
			dm_pkg::DM_BU: return {24'h0, b};
			default:       return 32'h0;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("mismatch %s: expected %h, actual %h at %0t ns", name, exp, act, $time);
		end
	endtask

	// negedge sampling, inputs change 2 ns after the rising edge
	always @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < dm_pkg::DM_WORDS; i++) begin
				model[i] = 32'h0;
			end
			pend = 1'b0;
			clr_cnt = 0;
			error_count = 0;
			check_count = 0;
		end else begin
			// busy holds for exactly DM_WORDS cycles after reset release
			exp_busy = (clr_cnt < dm_pkg::DM_WORDS);
			compare_value("busy", {31'h0, exp_busy}, {31'h0, busy});
			if (exp_busy) begin
				clr_cnt++;
			end
			op_addr = write_enable ? write_addr : read_addr;
			exp_valid = expect_valid(mode, op_addr);
			compare_value("valid", {31'h0, exp_valid}, {31'h0, valid});
			compare_value("test_m_addr", {op_addr[31:2], 2'b00}, test_m_addr);
			// only W, H and B stores write, and never while clearing
			exp_we = !exp_busy && exp_valid && write_enable && !stop &&
				(mode == dm_pkg::DM_W || mode == dm_pkg::DM_H || mode == dm_pkg::DM_B);
			compare_value("test_m_we", {31'h0, exp_we}, {31'h0, test_m_we});
			if (pend) begin
				compare_value("read_result", pend_result, read_result);
				compare_value("test_m_wdata", pend_word, test_m_wdata);
			end
			// the read happens before this cycle's store lands
			pend = !exp_busy && !write_enable;
			pend_word = model[read_addr[dm_pkg::DM_INDEX_W+1:2]];
			pend_result = exp_valid ? expect_load(mode, read_addr, pend_word) : 32'h0;
			if (test_m_we) begin
				widx = write_addr[dm_pkg::DM_INDEX_W+1:2];
				case (mode)
					dm_pkg::DM_W: model[widx] = write_data;
					dm_pkg::DM_H: model[widx][16*write_addr[1] +: 16] = write_data[15:0];
					dm_pkg::DM_B: model[widx][8*write_addr[1:0] +: 8] = write_data[7:0];
					default: begin
					end
				endcase
			end
		end
	end

endmodule

// File: verification/dm_tb.sv
module dm_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// clear takes DM_WORDS cycles, the rest is margin
	localparam int CLEAR_LIMIT = dm_pkg::DM_WORDS + 16;
	localparam int OPS = 200;
	localparam logic [2:0] LOAD_MODES [5] = '{dm_pkg::DM_W, dm_pkg::DM_H, dm_pkg::DM_HU,
		dm_pkg::DM_B, dm_pkg::DM_BU};

	logic        clk;
	logic        rst;
	logic [31:0] read_addr;
	logic [31:0] write_addr;
	logic [31:0] write_data;
	logic        write_enable;
	logic [2:0]  mode;
	logic        stop;
	logic [31:0] read_result;
	logic        valid;
	logic        busy;
	logic [31:0] test_m_addr;
	logic        test_m_we;
	logic [31:0] test_m_wdata;
	int          error_count;
	int          check_count;
	int          tests_passed;
	int          tests_failed;

	dm_top dm_top_inst (.*);
	// watches the ports and keeps the reference memory
	dm_checker checker_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// one request per cycle, the address port not in use gets random bits
	task automatic drive(input logic we, input logic [2:0] m, input logic [31:0] addr,
		input logic [31:0] data, input logic stp);
		@(posedge clk);
		#2;
		write_enable = we;
		mode = m;
		write_addr = we ? addr : $urandom;
		read_addr = we ? $urandom : addr;
		write_data = data;
		stop = stp;
	endtask

	// random word inside the window, low bits from the caller
	function automatic logic [31:0] pick_addr(input logic [1:0] low);
		return (32'($urandom_range(dm_pkg::DM_WORDS - 1)) << 2) | 32'(low);
	endfunction

	// aligned low address bits for an access size
	function automatic logic [1:0] pick_low(input logic [2:0] m);
		case (m)
			dm_pkg::DM_W: return 2'b00;
			dm_pkg::DM_H, dm_pkg::DM_HU: return {1'($urandom), 1'b0};
			default: return 2'($urandom);
		endcase
	endfunction

	task automatic finish_test(input string name, input int errs_before);
		// two idle cycles so the checker has seen the last load result
		repeat (2) drive(1'b0, dm_pkg::DM_NONE, 32'h0, 32'h0, 1'b0);
		if (error_count == errs_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed, %0d mismatches", name, error_count - errs_before);
		end
	endtask

	// stores issued while busy must be dropped
	task automatic wait_clear(output bit done);
		int cycles;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < CLEAR_LIMIT) begin
			drive(1'b1, dm_pkg::DM_W, pick_addr(2'b00), $urandom, 1'b0);
			cycles++;
			done = !busy;
		end
	endtask

	initial begin
		logic [31:0] addr;
		logic [2:0]  m;
		bit          clear_ok;
		int          errs;
		void'($urandom(32'hbee5));
		tests_passed = 0;
		tests_failed = 0;
		rst = 1'b1;
		write_enable = 1'b0;
		mode = dm_pkg::DM_NONE;
		write_addr = 32'h0;
		read_addr = 32'h0;
		write_data = 32'h0;
		stop = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		errs = error_count;
		wait_clear(clear_ok);
		if (!clear_ok) begin
			$display("timeout: busy still high after %0d cycles", CLEAR_LIMIT);
			tests_failed++;
		end else begin
			// every word reads back zero after the clear
			repeat (OPS) drive(1'b0, dm_pkg::DM_W, pick_addr(2'b00), 32'h0, 1'b0);
			finish_test("clear", errs);
			errs = error_count;
			repeat (OPS) begin
				addr = pick_addr(2'b00);
				drive(1'b1, dm_pkg::DM_W, addr, $urandom, 1'b0);
				drive(1'b0, dm_pkg::DM_W, addr, 32'h0, 1'b0);
				drive(1'b0, dm_pkg::DM_W, pick_addr(2'b00), 32'h0, 1'b0);
			end
			finish_test("word traffic", errs);
			errs = error_count;
			repeat (OPS) begin
				m = ($urandom_range(1) == 0) ? dm_pkg::DM_H : dm_pkg::DM_B;
				addr = pick_addr(pick_low(m));
				drive(1'b1, m, addr, $urandom, 1'b0);
				// any load mode at any aligned spot of the same word
				m = LOAD_MODES[$urandom_range(4)];
				drive(1'b0, m, {addr[31:2], pick_low(m)}, 32'h0, 1'b0);
			end
			finish_test("sub-word traffic", errs);
			errs = error_count;
			repeat (OPS / 4) begin
				addr = pick_addr(2'($urandom_range(1, 3)));
				drive(1'b1, dm_pkg::DM_W, addr, $urandom, 1'b0);
				drive(1'b0, dm_pkg::DM_W, {addr[31:2], 2'b00}, 32'h0, 1'b0);
				addr = pick_addr({1'($urandom), 1'b1});
				drive(1'b1, dm_pkg::DM_H, addr, $urandom, 1'b0);
				drive(1'b0, dm_pkg::DM_HU, addr, 32'h0, 1'b0);
				// above the window, the index bits still name a real word
				addr = $urandom | (dm_pkg::DM_ADDR_UB + 1);
				drive(1'b1, dm_pkg::DM_W, addr, $urandom, 1'b0);
				drive(1'b0, dm_pkg::DM_W, addr, 32'h0, 1'b0);
				drive(1'b0, dm_pkg::DM_W, addr & dm_pkg::DM_ADDR_UB & ~32'h3, 32'h0, 1'b0);
				drive(1'b0, dm_pkg::DM_NONE, pick_addr(2'($urandom)), 32'h0, 1'b0);
			end
			finish_test("rejection", errs);
			errs = error_count;
			repeat (OPS / 2) begin
				addr = pick_addr(2'($urandom));
				drive(1'b1, dm_pkg::DM_B, addr, $urandom, 1'b1);
				drive(1'b1, dm_pkg::DM_W, {addr[31:2], 2'b00}, $urandom, 1'b1);
				drive(1'b0, dm_pkg::DM_W, {addr[31:2], 2'b00}, 32'h0, 1'b0);
			end
			finish_test("stop", errs);
		end
		$display("tests passed %0d, failed %0d, checks %0d, mismatches %0d",
			tests_passed, tests_failed, check_count, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
rtl/dm_pkg.sv
rtl/dm_ram_if.sv
rtl/dm_access_check.sv
rtl/dm_clear_ctrl.sv
rtl/dm_ram.sv
rtl/dm_load_extend.sv
rtl/dm_top.sv
verification/dm_checker.sv
verification/dm_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing -Wno-fatal --top-module dm_tb -f list.f -o dm_sim &&
./obj_dir/dm_sim > sim.log 2>&1
grep -qs "ALL TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
